// ==== hw/spi_link_config.svh ====
`ifndef SPI_LINK_CONFIG_SVH
`define SPI_LINK_CONFIG_SVH

// bits per spi frame, address plus data
`define SPI_FRAME_BITS 18

// payload carried by every request and response
`define SPI_DATA_BITS 16

// entries in the echo peer fifo
`define ECHO_DEPTH 2

`endif

// ==== hw/spi_link_pkg.sv ====
`include "spi_link_config.svh"

package spi_link_pkg;

  // request address, top two bits of a frame
  typedef enum logic [`SPI_FRAME_BITS-`SPI_DATA_BITS-1:0] {
    addr_echo  = 2'd0,
    addr_accum = 2'd1,
    addr_clear = 2'd2,
    addr_poll  = 2'd3
  } addr_e;

  // source codes in a response frame
  localparam logic src_echo  = 1'b0;
  localparam logic src_accum = 1'b1;

  // host to chip
  typedef struct packed {
    addr_e                     addr;
    logic [`SPI_DATA_BITS-1:0] data;
  } req_frame_t;

  // chip to host, valid in the msb so an idle frame reads as zeros
  typedef struct packed {
    logic                      valid;
    logic                      src;
    logic [`SPI_DATA_BITS-1:0] data;
  } rsp_frame_t;

endpackage

// ==== hw/spi_minion.sv ====
`timescale 1ns/1ns
`include "spi_link_config.svh"

module spi_minion (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    cs,
  input  logic                    sclk,
  input  logic                    mosi,
  output logic                    miso,
  output logic                    req_val,
  output spi_link_pkg::req_frame_t req_msg,
  input  logic                    req_rdy,
  input  logic                    out_val,
  input  spi_link_pkg::rsp_frame_t out_msg,
  output logic                    out_rdy,
  output logic                    minion_parity,
  output logic                    adapter_parity
);

  localparam int CNT_BITS = $clog2(`SPI_FRAME_BITS + 1);

  // [0] first sync flop, [1] synchronized, [2] history for edges
  logic [2:0] cs_sync;
  logic [2:0] sclk_sync;
  logic [1:0] mosi_sync;

  logic cs_rise;
  logic cs_fall;
  logic sclk_rise;
  logic sclk_fall;
  logic frame_done;

  logic [`SPI_FRAME_BITS-1:0] rx_shift;
  logic [`SPI_FRAME_BITS-1:0] tx_shift;
  logic [CNT_BITS-1:0]        bit_cnt;

  // cs idles high, so its sync chain comes out of reset high
  always_ff @(posedge clk) begin
    if (reset) begin
      cs_sync   <= 3'b111;
      sclk_sync <= 3'b000;
      mosi_sync <= 2'b00;
    end else begin
      cs_sync   <= {cs_sync[1:0], cs};
      sclk_sync <= {sclk_sync[1:0], sclk};
      mosi_sync <= {mosi_sync[0], mosi};
    end
  end

  assign cs_rise   = cs_sync[1] & ~cs_sync[2];
  assign cs_fall   = ~cs_sync[1] & cs_sync[2];
  // sclk edges only count inside a frame
  assign sclk_rise = sclk_sync[1] & ~sclk_sync[2] & ~cs_sync[1];
  assign sclk_fall = ~sclk_sync[1] & sclk_sync[2] & ~cs_sync[1];

  // full frame seen when cs goes back high
  assign frame_done = cs_rise && (bit_cnt == CNT_BITS'(`SPI_FRAME_BITS));

  // receive side, msb first
  always_ff @(posedge clk) begin
    if (sclk_rise) begin
      rx_shift <= {rx_shift[`SPI_FRAME_BITS-2:0], mosi_sync[1]};
    end
  end

  // count sampled bits, saturating past a full frame
  always_ff @(posedge clk) begin
    if (reset || cs_fall) begin
      bit_cnt <= '0;
    end else if (sclk_rise && bit_cnt != CNT_BITS'(`SPI_FRAME_BITS)) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // request register, new frame dropped while the old one waits
  always_ff @(posedge clk) begin
    if (reset) begin
      req_val       <= 1'b0;
      minion_parity <= 1'b0;
    end else begin
      if (frame_done && !req_val) begin
        req_val <= 1'b1;
      end else if (req_val && req_rdy) begin
        req_val <= 1'b0;
      end
      if (frame_done) begin
        minion_parity <= ^rx_shift;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (frame_done && !req_val) begin
      req_msg <= spi_link_pkg::req_frame_t'(rx_shift);
    end
  end

  // transmit side, loaded at frame start and shifted on falling sclk
  always_ff @(posedge clk) begin
    if (reset) begin
      tx_shift       <= '0;
      adapter_parity <= 1'b0;
    end else if (cs_fall) begin
      tx_shift       <= out_val ? out_msg : '0;
      adapter_parity <= out_val ? ^out_msg : 1'b0;
    end else if (sclk_fall) begin
      tx_shift <= {tx_shift[`SPI_FRAME_BITS-2:0], 1'b0};
    end
  end

  // response taken only at the start of a frame
  assign out_rdy = cs_fall;
  assign miso    = tx_shift[`SPI_FRAME_BITS-1];

endmodule

// ==== hw/frame_router.sv ====
`timescale 1ns/1ns
`include "spi_link_config.svh"

module frame_router (
  input  logic                      req_val,
  input  spi_link_pkg::req_frame_t  req_msg,
  output logic                      req_rdy,
  output logic                      echo_val,
  output logic [`SPI_DATA_BITS-1:0] echo_data,
  input  logic                      echo_rdy,
  output logic                      accum_val,
  output logic [`SPI_DATA_BITS-1:0] accum_data,
  input  logic                      accum_rdy,
  output logic                      accum_clear
);

  // payload fans out to both peers while val picks the target
  assign echo_data  = req_msg.data;
  assign accum_data = req_msg.data;

  always_comb begin
    echo_val    = 1'b0;
    accum_val   = 1'b0;
    accum_clear = 1'b0;
    req_rdy     = 1'b1;
    case (req_msg.addr)
      spi_link_pkg::addr_echo: begin
        echo_val = req_val;
        req_rdy  = echo_rdy;
      end
      spi_link_pkg::addr_accum: begin
        accum_val = req_val;
        req_rdy   = accum_rdy;
      end
      // consumed at once so the pulse lasts one cycle
      spi_link_pkg::addr_clear: begin
        accum_clear = req_val;
      end
      // poll only exists to clock a response out
      spi_link_pkg::addr_poll: begin
        req_rdy = 1'b1;
      end
    endcase
  end

endmodule

// ==== hw/echo_peer.sv ====
`timescale 1ns/1ns
`include "spi_link_config.svh"

module echo_peer (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      in_val,
  input  logic [`SPI_DATA_BITS-1:0] in_data,
  output logic                      in_rdy,
  output logic                      rsp_val,
  output spi_link_pkg::rsp_frame_t  rsp_msg,
  input  logic                      rsp_rdy
);

  localparam int DEPTH    = `ECHO_DEPTH;
  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  logic [`SPI_DATA_BITS-1:0] mem [DEPTH];
  logic [PTR_BITS-1:0]       wr_ptr;
  logic [PTR_BITS-1:0]       rd_ptr;
  logic [CNT_BITS-1:0]       count;
  logic                      push;
  logic                      pop;

  assign in_rdy  = (count != CNT_BITS'(DEPTH));
  assign rsp_val = (count != '0);
  assign push    = in_val && in_rdy;
  assign pop     = rsp_val && rsp_rdy;

  // entry storage written on push
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // pointers wrap at a depth that need not be a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_BITS'(push) - CNT_BITS'(pop);
    end
  end

  // head entry goes back unchanged
  assign rsp_msg.valid = 1'b1;
  assign rsp_msg.src   = spi_link_pkg::src_echo;
  assign rsp_msg.data  = mem[rd_ptr];

endmodule

// ==== hw/accum_peer.sv ====
`timescale 1ns/1ns
`include "spi_link_config.svh"

module accum_peer (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      clear,
  input  logic                      in_val,
  input  logic [`SPI_DATA_BITS-1:0] in_data,
  output logic                      in_rdy,
  output logic                      rsp_val,
  output spi_link_pkg::rsp_frame_t  rsp_msg,
  input  logic                      rsp_rdy
);

  logic [`SPI_DATA_BITS-1:0] sum;
  logic [`SPI_DATA_BITS-1:0] sum_next;
  logic [`SPI_DATA_BITS-1:0] reply_data;
  logic                      reply_full;
  logic                      accept;

  // one reply outstanding at a time
  assign in_rdy   = !reply_full;
  assign accept   = in_val && in_rdy;
  // wraps modulo 2^16
  assign sum_next = sum + in_data;

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      sum <= '0;
    end else if (accept) begin
      sum <= sum_next;
    end
  end

  // clear leaves a pending reply alone
  always_ff @(posedge clk) begin
    if (reset) begin
      reply_full <= 1'b0;
    end else if (accept) begin
      reply_full <= 1'b1;
    end else if (rsp_val && rsp_rdy) begin
      reply_full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reply_data <= sum_next;
    end
  end

  assign rsp_val       = reply_full;
  assign rsp_msg.valid = 1'b1;
  assign rsp_msg.src   = spi_link_pkg::src_accum;
  assign rsp_msg.data  = reply_data;

endmodule

// ==== hw/response_arbiter.sv ====
`timescale 1ns/1ns

module response_arbiter (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     echo_val,
  input  spi_link_pkg::rsp_frame_t echo_msg,
  output logic                     echo_rdy,
  input  logic                     accum_val,
  input  spi_link_pkg::rsp_frame_t accum_msg,
  output logic                     accum_rdy,
  output logic                     out_val,
  output spi_link_pkg::rsp_frame_t out_msg,
  input  logic                     out_rdy
);

  // priority pointer, low favours echo
  logic prio_accum;
  logic grant_echo;
  logic grant_accum;

  logic                     buf_val;
  spi_link_pkg::rsp_frame_t buf_msg;

  // pointer only matters when both peers ask
  assign grant_echo  = echo_val && (!prio_accum || !accum_val);
  assign grant_accum = accum_val && (prio_accum || !echo_val);

  // grants only into an empty buffer
  assign echo_rdy  = !buf_val && grant_echo;
  assign accum_rdy = !buf_val && grant_accum;

  always_ff @(posedge clk) begin
    if (reset) begin
      buf_val    <= 1'b0;
      prio_accum <= 1'b0;
    end else if (!buf_val && (grant_echo || grant_accum)) begin
      buf_val    <= 1'b1;
      // hand priority to the peer that lost
      prio_accum <= grant_echo;
    end else if (buf_val && out_rdy) begin
      buf_val <= 1'b0;
    end
  end

  // one-entry output buffer, payload only
  always_ff @(posedge clk) begin
    if (!buf_val && grant_echo) begin
      buf_msg <= echo_msg;
    end else if (!buf_val && grant_accum) begin
      buf_msg <= accum_msg;
    end
  end

  assign out_val = buf_val;
  assign out_msg = buf_msg;

endmodule

// ==== hw/spi_link_top.sv ====
`timescale 1ns/1ns
`include "spi_link_config.svh"

module spi_link_top (
  input  logic clk,
  input  logic reset,
  input  logic cs,
  input  logic sclk,
  input  logic mosi,
  output logic miso,
  output logic minion_parity,
  output logic adapter_parity
);

  // request path
  logic                      req_val;
  logic                      req_rdy;
  spi_link_pkg::req_frame_t  req_msg;
  logic                      echo_in_val;
  logic                      echo_in_rdy;
  logic [`SPI_DATA_BITS-1:0] echo_in_data;
  logic                      accum_in_val;
  logic                      accum_in_rdy;
  logic [`SPI_DATA_BITS-1:0] accum_in_data;
  logic                      accum_clear;

  // response path
  logic                      echo_rsp_val;
  logic                      echo_rsp_rdy;
  spi_link_pkg::rsp_frame_t  echo_rsp_msg;
  logic                      accum_rsp_val;
  logic                      accum_rsp_rdy;
  spi_link_pkg::rsp_frame_t  accum_rsp_msg;
  logic                      out_val;
  logic                      out_rdy;
  spi_link_pkg::rsp_frame_t  out_msg;

  spi_minion minion_i (
    .clk(clk), .reset(reset), .cs(cs), .sclk(sclk), .mosi(mosi), .miso(miso),
    .req_val(req_val), .req_msg(req_msg), .req_rdy(req_rdy),
    .out_val(out_val), .out_msg(out_msg), .out_rdy(out_rdy),
    .minion_parity(minion_parity), .adapter_parity(adapter_parity)
  );

  frame_router router_i (
    .req_val(req_val), .req_msg(req_msg), .req_rdy(req_rdy),
    .echo_val(echo_in_val), .echo_data(echo_in_data), .echo_rdy(echo_in_rdy),
    .accum_val(accum_in_val), .accum_data(accum_in_data), .accum_rdy(accum_in_rdy),
    .accum_clear(accum_clear)
  );

  echo_peer echo_i (
    .clk(clk), .reset(reset),
    .in_val(echo_in_val), .in_data(echo_in_data), .in_rdy(echo_in_rdy),
    .rsp_val(echo_rsp_val), .rsp_msg(echo_rsp_msg), .rsp_rdy(echo_rsp_rdy)
  );

  accum_peer accum_i (
    .clk(clk), .reset(reset), .clear(accum_clear),
    .in_val(accum_in_val), .in_data(accum_in_data), .in_rdy(accum_in_rdy),
    .rsp_val(accum_rsp_val), .rsp_msg(accum_rsp_msg), .rsp_rdy(accum_rsp_rdy)
  );

  response_arbiter arbiter_i (
    .clk(clk), .reset(reset),
    .echo_val(echo_rsp_val), .echo_msg(echo_rsp_msg), .echo_rdy(echo_rsp_rdy),
    .accum_val(accum_rsp_val), .accum_msg(accum_rsp_msg), .accum_rdy(accum_rsp_rdy),
    .out_val(out_val), .out_msg(out_msg), .out_rdy(out_rdy)
  );

endmodule

// ==== dv/spi_link_tb.sv ====
`timescale 1ns/1ns
`include "spi_link_config.svh"

module spi_link_tb;

  localparam int FB = `SPI_FRAME_BITS;
  localparam int DB = `SPI_DATA_BITS;
  // clk cycles per sclk phase
  localparam int PHASE = 6;
  localparam int POLL_LIMIT = 20;
  localparam int IDLE_LIMIT = 20;

  logic clk;
  logic reset;
  logic cs;
  logic sclk;
  logic mosi;
  logic miso;
  logic minion_parity;
  logic adapter_parity;

  // per frame records filled by the spi host and drained at posedge
  logic [FB-1:0] sent_q[$];
  logic [FB-1:0] got_q[$];
  logic          mpar_q[$];
  logic          apar_q[$];
  // expected responses in request order
  logic [FB-1:0] exp_q[$];
  logic [DB-1:0] model_sum;

  spi_link_top dut_i (
    .clk(clk), .reset(reset), .cs(cs), .sclk(sclk), .mosi(mosi), .miso(miso),
    .minion_parity(minion_parity), .adapter_parity(adapter_parity)
  );

  always #10 clk = ~clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [FB-1:0] got,
                             input logic [FB-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Error at %0t ns: %s got 0x%0h expected 0x%0h",
                         $time, name, got, exp));
    end
  endtask

  task automatic wait_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
    end
  endtask

  // expected reply for one request or zero when none is due
  function automatic logic [FB-1:0] expected_rsp(input logic [1:0] addr,
                                                 input logic [DB-1:0] data,
                                                 input logic [DB-1:0] sum);
    logic [DB-1:0] new_sum;
    new_sum = sum + data;
    case (addr)
      spi_link_pkg::addr_echo:  expected_rsp = {1'b1, 1'b0, data};
      spi_link_pkg::addr_accum: expected_rsp = {1'b1, 1'b1, new_sum};
      default:                  expected_rsp = '0;
    endcase
  endfunction

  // mode 0 host sending msb first
  // miso read just before each rising sclk
  task automatic transfer_frame(input logic [FB-1:0] tx, output logic [FB-1:0] rx);
    cs = 1'b0;
    for (int i = FB - 1; i >= 0; i--) begin
      mosi = tx[i];
      wait_cycles(PHASE);
      rx[i] = miso;
      sclk = 1'b1;
      wait_cycles(PHASE);
      sclk = 1'b0;
    end
    wait_cycles(PHASE);
    cs   = 1'b1;
    mosi = 1'b0;
    // request settles into the arbiter buffer well within this gap
    wait_cycles(9);
    sent_q.push_back(tx);
    got_q.push_back(rx);
    mpar_q.push_back(minion_parity);
    apar_q.push_back(adapter_parity);
    // compare runs here before this frame's reply is queued
    wait_cycles(1);
  endtask

  task automatic send_request(input logic [1:0] addr, input logic [DB-1:0] data,
                              output logic [FB-1:0] rx);
    logic [FB-1:0] rsp;
    transfer_frame({addr, data}, rx);
    rsp = expected_rsp(addr, data, model_sum);
    if (addr == spi_link_pkg::addr_accum) begin
      model_sum = rsp[DB-1:0];
    end else if (addr == spi_link_pkg::addr_clear) begin
      model_sum = '0;
    end
    if (rsp[FB-1]) begin
      exp_q.push_back(rsp);
    end
  endtask

  // poll frames until one carries a valid reply
  task automatic poll_for_response();
    logic [FB-1:0] rx;
    int            frames;
    frames = 0;
    rx     = '0;
    while (!rx[FB-1] && frames < POLL_LIMIT) begin
      send_request(spi_link_pkg::addr_poll, '0, rx);
      frames++;
    end
    if (!rx[FB-1]) begin
      fail_run($sformatf("no valid response after %0d poll frames", POLL_LIMIT));
    end
  endtask

  task automatic wait_compare_idle();
    int cycles;
    cycles = 0;
    while (got_q.size() != 0 && cycles < IDLE_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (got_q.size() != 0) begin
      fail_run("captured frames were never compared");
    end
  endtask

  task automatic compare_frame();
    logic [FB-1:0] sent;
    logic [FB-1:0] got;
    logic [FB-1:0] exp;
    logic          mpar;
    logic          apar;
    sent = sent_q.pop_front();
    got  = got_q.pop_front();
    mpar = mpar_q.pop_front();
    apar = apar_q.pop_front();
    check_value("minion_parity", FB'(mpar), FB'(^sent));
    if (got[FB-1]) begin
      if (exp_q.size() == 0) begin
        fail_run($sformatf("valid frame 0x%0h arrived with no request pending", got));
      end else begin
        exp = exp_q.pop_front();
        check_value("miso frame", got, exp);
        check_value("adapter_parity", FB'(apar), FB'(^exp));
      end
    end else begin
      // a pending reply must ride out on the very next frame
      if (exp_q.size() != 0) begin
        fail_run($sformatf("response 0x%0h missing from the next miso frame", exp_q[0]));
      end
      // idle frame must be all zeros
      check_value("miso frame", got, '0);
      check_value("adapter_parity", FB'(apar), '0);
    end
  endtask

  always @(posedge clk) begin
    while (got_q.size() != 0) begin
      compare_frame();
    end
  end

  initial begin
    logic [FB-1:0] rx;
    logic [DB-1:0] data;
    logic [1:0]    addr;
    void'($urandom(32'he289_3700));
    clk       = 1'b0;
    reset     = 1'b1;
    cs        = 1'b1;
    sclk      = 1'b0;
    mosi      = 1'b0;
    model_sum = '0;
    wait_cycles(2);
    reset = 1'b0;
    wait_cycles(4);

    // idle polls read zeros
    send_request(spi_link_pkg::addr_poll, '0, rx);
    send_request(spi_link_pkg::addr_poll, 16'hffff, rx);

    // each echo reply rides out on the following frame
    for (int i = 0; i < 20; i++) begin
      data = DB'($urandom);
      send_request(spi_link_pkg::addr_echo, data, rx);
    end
    poll_for_response();

    // accumulator with the top bit forced on the first two so the sum wraps
    for (int i = 0; i < 20; i++) begin
      data = DB'($urandom);
      if (i < 2) begin
        data[DB-1] = 1'b1;
      end
      send_request(spi_link_pkg::addr_accum, data, rx);
    end
    poll_for_response();

    // clear gives no reply and the sum restarts
    send_request(spi_link_pkg::addr_clear, DB'($urandom), rx);
    send_request(spi_link_pkg::addr_poll, '0, rx);
    data = DB'($urandom);
    send_request(spi_link_pkg::addr_accum, data, rx);
    poll_for_response();

    // mixed traffic checks order and source bits
    for (int i = 0; i < 16; i++) begin
      addr = ($urandom & 1) ? spi_link_pkg::addr_accum : spi_link_pkg::addr_echo;
      data = DB'($urandom);
      send_request(addr, data, rx);
    end
    poll_for_response();
    send_request(spi_link_pkg::addr_poll, '0, rx);

    wait_compare_idle();
    if (exp_q.size() != 0) begin
      fail_run($sformatf("%0d expected responses never arrived", exp_q.size()));
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

// ==== files.f ====
+incdir+hw
hw/spi_link_pkg.sv
hw/spi_minion.sv
hw/frame_router.sv
hw/echo_peer.sv
hw/accum_peer.sv
hw/response_arbiter.sv
hw/spi_link_top.sv
dv/spi_link_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the spi link testbench with verilator
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f files.f \
  --top-module spi_link_tb -o spi_link_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/spi_link_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0
